//--- motion_pkg.sv
package motion_pkg;

    // ======================================================================
    // Sensor sample encoding
    // ======================================================================

    // One yaw or angular-rate reading, two's complement sensor units
    typedef logic signed [15:0] sample_t;

    // Hand select, right hand is sensor 1
    typedef logic [0:0] hand_t;

    localparam hand_t HAND_RIGHT = 1'b0;  // Sensor 1
    localparam hand_t HAND_LEFT  = 1'b1;  // Sensor 2

    localparam int HAND_COUNT = 2;  // Per-hand state arrays

    // ======================================================================
    // Strike detection defaults
    // ======================================================================

    // Magnitude of the downward rate that counts as a strike
    localparam sample_t DEF_STRIKE_RATE = 16'sd2000;

    // Magnitude below which the stick is considered lifted again
    // Must stay smaller than the strike level or strikes retrigger
    localparam sample_t DEF_REARM_RATE = 16'sd500;

endpackage

//--- drum_pkg.sv
package drum_pkg;

    // ======================================================================
    // Drum codes
    // ======================================================================

    typedef logic [3:0] drum_code_t;

    localparam drum_code_t DRUM_KICK  = 4'd0;  // Pedal button
    localparam drum_code_t DRUM_SNARE = 4'd1;  // Centre sector
    localparam drum_code_t DRUM_HIHAT = 4'd2;  // Yaw above the centre sector
    localparam drum_code_t DRUM_TOM   = 4'd3;  // Yaw below the centre sector

    // Half-width of the snare sector around the calibrated centre
    localparam int DEF_ZONE_EDGE = 2048;

    // ======================================================================
    // MCU byte layout
    // ======================================================================

    // Bit 7 hand, bits 6..4 zero, bits 3..0 drum code
    typedef logic [7:0] mcu_byte_t;

    // Builds the byte handed to the MCU
    function automatic mcu_byte_t pack_mcu_byte(input logic hand,
                                                input drum_code_t code);
        mcu_byte_t b;
        b = {hand, 3'b000, code};
        return b;
    endfunction

endpackage

//--- motion_if.sv
`timescale 1ns/1ps

// One merged motion sample, right or left hand
interface motion_if;
    import motion_pkg::*;

    logic    valid;  // One-cycle strobe
    hand_t   hand;   // Source hand, meaningful with valid
    sample_t yaw;    // Absolute heading
    sample_t rate;   // Downward angular rate, negative when striking

    // Merge stage drives the sample
    modport src (
        output valid, hand, yaw, rate
    );

    // Strike stage consumes it
    modport dst (
        input valid, hand, yaw, rate
    );

endinterface

//--- reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int SENSOR_DELAY     = 300_000,   // Cycles to sensor release
    parameter int CONTROLLER_DELAY = 6_000_000  // Cycles to pipeline release
) (
    input  logic clk,
    input  logic fpga_rst_n,
    output logic bno085_rst_n,
    output logic rst_n
);

    localparam int CNT_W = $clog2(CONTROLLER_DELAY + 1);

    // Compare one early since the outputs are registered
    localparam logic [CNT_W-1:0] SENSOR_LAST = CNT_W'(SENSOR_DELAY - 1);
    localparam logic [CNT_W-1:0] CTRL_LAST   = CNT_W'(CONTROLLER_DELAY - 1);
    localparam logic [CNT_W-1:0] CNT_MAX     = CNT_W'(CONTROLLER_DELAY);

    logic [CNT_W-1:0] cnt;  // Cycles since fpga_rst_n released

    always_ff @(posedge clk or negedge fpga_rst_n) begin
        if (!fpga_rst_n) begin
            cnt          <= '0;
            bno085_rst_n <= 1'b0;
            rst_n        <= 1'b0;
        end else begin
            if (cnt < CNT_MAX) begin
                cnt <= cnt + 1'b1;  // Saturates, holds at the last delay
            end
            bno085_rst_n <= (cnt >= SENSOR_LAST);
            rst_n        <= (cnt >= CTRL_LAST);
        end
    end

endmodule

//--- button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 150_000  // Stable cycles before a change is accepted
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_n,    // Raw button, low when pressed
    output logic pressed   // One-cycle pulse on press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [1:0]       sync_n;     // Two-flop synchroniser, active low
    logic             level;      // Synchronised level, high = pressed
    logic             state;      // Debounced level, high = pressed
    logic [CNT_W-1:0] stable_cnt;

    assign level = ~sync_n[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_n     <= 2'b11;  // Released
            state      <= 1'b0;
            stable_cnt <= '0;
            pressed    <= 1'b0;
        end else begin
            sync_n  <= {sync_n[0], btn_n};
            pressed <= 1'b0;
            if (level == state) begin
                stable_cnt <= '0;  // Glitch ended, start over
            end else if (stable_cnt == CNT_LAST) begin
                stable_cnt <= '0;
                state      <= level;
                pressed    <= level;  // Only released -> pressed pulses
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hand_sample_merge.sv
`timescale 1ns/1ps

module hand_sample_merge (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 right_valid,
    input  motion_pkg::sample_t  right_yaw,
    input  motion_pkg::sample_t  right_rate,
    input  logic                 left_valid,
    input  motion_pkg::sample_t  left_yaw,
    input  motion_pkg::sample_t  left_rate,
    motion_if.src                motion
);
    import motion_pkg::*;

    // Holding registers, one sample deep per hand
    sample_t r_yaw, r_rate, l_yaw, l_rate;
    logic    r_full, l_full;
    hand_t   last_grant;  // Hand sent most recently

    // Candidates, a fresh sample wins over the buffered one
    sample_t r_yaw_c, r_rate_c, l_yaw_c, l_rate_c;
    logic    r_avail, l_avail;
    logic    grant_left;

    assign r_avail  = right_valid | r_full;
    assign l_avail  = left_valid  | l_full;
    assign r_yaw_c  = right_valid ? right_yaw  : r_yaw;
    assign r_rate_c = right_valid ? right_rate : r_rate;
    assign l_yaw_c  = left_valid  ? left_yaw   : l_yaw;
    assign l_rate_c = left_valid  ? left_rate  : l_rate;

    // Alternate when both wait, otherwise take whichever is there
    assign grant_left = l_avail && (!r_avail || (last_grant == HAND_RIGHT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_full       <= 1'b0;
            l_full       <= 1'b0;
            last_grant   <= HAND_LEFT;  // Right goes first on a tie
            motion.valid <= 1'b0;
        end else begin
            motion.valid <= r_avail | l_avail;
            if (r_avail | l_avail) begin
                last_grant <= grant_left ? HAND_LEFT : HAND_RIGHT;
            end
            // Granted hand is consumed, the other keeps or refreshes its buffer
            r_full <= grant_left ? r_avail : 1'b0;
            l_full <= grant_left ? 1'b0 : l_avail;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        r_yaw  <= r_yaw_c;
        r_rate <= r_rate_c;
        l_yaw  <= l_yaw_c;
        l_rate <= l_rate_c;
        motion.hand <= grant_left ? HAND_LEFT : HAND_RIGHT;
        motion.yaw  <= grant_left ? l_yaw_c  : r_yaw_c;
        motion.rate <= grant_left ? l_rate_c : r_rate_c;
    end

endmodule

//--- strike_detector.sv
`timescale 1ns/1ps

module strike_detector #(
    parameter motion_pkg::sample_t STRIKE_RATE = motion_pkg::DEF_STRIKE_RATE,
    parameter motion_pkg::sample_t REARM_RATE  = motion_pkg::DEF_REARM_RATE
) (
    input  logic                 clk,
    input  logic                 rst_n,
    motion_if.dst                motion,
    input  logic                 calibrate,     // Debounced calibrate pulse
    output logic                 strike_valid,
    output motion_pkg::hand_t    strike_hand,
    output motion_pkg::sample_t  strike_yaw     // Yaw relative to calibrated centre
);
    import motion_pkg::*;

    // Downward rate is negative, thresholds are mirrored
    localparam sample_t STRIKE_LEVEL = -STRIKE_RATE;
    localparam sample_t REARM_LEVEL  = -REARM_RATE;

    logic [HAND_COUNT-1:0] armed;     // Ready for the next strike
    logic [HAND_COUNT-1:0] cal_pend;  // Next sample becomes the centre
    sample_t               offset [HAND_COUNT];

    logic    hit;   // Strike on the current sample
    sample_t rel_yaw;

    // ======================================================================
    // Per-hand decision on the incoming sample
    // ======================================================================

    assign hit     = motion.valid && !cal_pend[motion.hand] && armed[motion.hand]
                     && (motion.rate <= STRIKE_LEVEL);
    assign rel_yaw = motion.yaw - offset[motion.hand];  // Wraps at 16 bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed        <= '1;
            cal_pend     <= '0;
            offset[0]    <= '0;
            offset[1]    <= '0;
            strike_valid <= 1'b0;
            strike_hand  <= HAND_RIGHT;
            strike_yaw   <= '0;
        end else begin
            strike_valid <= hit;
            if (motion.valid) begin
                if (cal_pend[motion.hand]) begin
                    offset[motion.hand]   <= motion.yaw;  // Calibration sample, never strikes
                    cal_pend[motion.hand] <= 1'b0;
                end else if (hit) begin
                    armed[motion.hand] <= 1'b0;
                    strike_hand        <= motion.hand;
                    strike_yaw         <= rel_yaw;
                end else if (motion.rate >= REARM_LEVEL) begin
                    armed[motion.hand] <= 1'b1;  // Stick lifted
                end
            end
            if (calibrate) begin
                cal_pend <= '1;  // Both hands recentre
            end
        end
    end

endmodule

//--- drum_classifier.sv
`timescale 1ns/1ps

module drum_classifier #(
    parameter motion_pkg::sample_t ZONE_EDGE = motion_pkg::sample_t'(drum_pkg::DEF_ZONE_EDGE)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 strike_valid,
    input  motion_pkg::hand_t    strike_hand,
    input  motion_pkg::sample_t  strike_yaw,
    input  logic                 kick,          // Debounced pedal pulse
    output logic                 event_valid,
    output motion_pkg::hand_t    event_hand,
    output drum_pkg::drum_code_t event_code
);
    import motion_pkg::*;
    import drum_pkg::*;

    localparam sample_t ZONE_LOW = -ZONE_EDGE;

    logic       kick_pend;  // Kick deferred behind a strike
    drum_code_t zone_code;

    // Sector lookup on relative yaw
    always_comb begin
        if (strike_yaw > ZONE_EDGE) begin
            zone_code = DRUM_HIHAT;
        end else if (strike_yaw < ZONE_LOW) begin
            zone_code = DRUM_TOM;
        end else begin
            zone_code = DRUM_SNARE;  // Edges inclusive
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            event_valid <= 1'b0;
            event_hand  <= HAND_RIGHT;
            event_code  <= DRUM_KICK;
            kick_pend   <= 1'b0;
        end else begin
            event_valid <= strike_valid | kick | kick_pend;
            if (strike_valid) begin
                event_hand <= strike_hand;
                event_code <= zone_code;
                kick_pend  <= kick_pend | kick;  // Strike has the slot
            end else if (kick || kick_pend) begin
                event_hand <= HAND_RIGHT;  // Pedal reported as right hand
                event_code <= DRUM_KICK;
                kick_pend  <= 1'b0;
            end
        end
    end

endmodule

//--- mcu_spi_slave.sv
`timescale 1ns/1ps

module mcu_spi_slave (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 event_valid,
    input  motion_pkg::hand_t    event_hand,
    input  drum_pkg::drum_code_t event_code,
    input  logic                 mcu_sck,    // MCU samples on rising edge
    input  logic                 mcu_load,   // High for the whole byte
    output logic                 mcu_sdo,
    output logic                 mcu_done    // Event waiting for the MCU
);
    import drum_pkg::*;

    // Two synchroniser flops plus one for edge detect
    logic [2:0] sck_sync;
    logic [2:0] load_sync;
    logic       sck_fall, load_rise, load_fall, load_level;

    logic       pending;
    mcu_byte_t  tx_byte;   // Latched event
    logic [2:0] bit_idx;   // Bit on mcu_sdo, MSB first

    assign sck_fall   =  sck_sync[2]  & ~sck_sync[1];
    assign load_rise  = ~load_sync[2] &  load_sync[1];
    assign load_fall  =  load_sync[2] & ~load_sync[1];
    assign load_level =  load_sync[2];  // Lines up with bit_idx reset

    assign mcu_done = pending;
    assign mcu_sdo  = load_level & tx_byte[bit_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync  <= '0;
            load_sync <= '0;
            pending   <= 1'b0;
            bit_idx   <= 3'd7;
            tx_byte   <= '0;  // Keeps mcu_sdo defined before the first event
        end else begin
            sck_sync  <= {sck_sync[1:0], mcu_sck};
            load_sync <= {load_sync[1:0], mcu_load};

            // ==============================================================
            // Event capture, one deep
            // ==============================================================
            if (load_fall) begin
                pending <= 1'b0;  // MCU finished the read
            end else if (event_valid && !pending) begin
                pending <= 1'b1;
                tx_byte <= pack_mcu_byte(event_hand, event_code);
            end
            // Events while pending are dropped

            // ==============================================================
            // Shift position
            // ==============================================================
            if (load_rise) begin
                bit_idx <= 3'd7;
            end else if (load_level && sck_fall) begin
                bit_idx <= bit_idx - 1'b1;
            end
        end
    end

endmodule

//--- drum_trigger_top.sv
`timescale 1ns/1ps

module drum_trigger_top #(
    parameter int SENSOR_DELAY     = 300_000,    // About 100 ms at 3 MHz
    parameter int CONTROLLER_DELAY = 6_000_000,  // About 2 s at 3 MHz
    parameter int DEBOUNCE_CYCLES  = 150_000,
    parameter motion_pkg::sample_t STRIKE_RATE = motion_pkg::DEF_STRIKE_RATE,
    parameter motion_pkg::sample_t REARM_RATE  = motion_pkg::DEF_REARM_RATE,
    parameter motion_pkg::sample_t ZONE_EDGE   =
        motion_pkg::sample_t'(drum_pkg::DEF_ZONE_EDGE)
) (
    input  logic                clk,
    input  logic                fpga_rst_n,
    // Right hand sensor, sensor 1
    input  logic                right_valid,
    input  motion_pkg::sample_t right_yaw,
    input  motion_pkg::sample_t right_rate,
    // Left hand sensor, sensor 2
    input  logic                left_valid,
    input  motion_pkg::sample_t left_yaw,
    input  motion_pkg::sample_t left_rate,
    input  logic                calibrate_btn_n,
    input  logic                kick_btn_n,
    // MCU link
    input  logic                mcu_sck,
    input  logic                mcu_load,
    output logic                mcu_sdo,
    output logic                mcu_done,
    output logic                bno085_rst_n,  // Shared by both sensors
    output logic                led_ready
);
    import motion_pkg::*;
    import drum_pkg::*;

    logic       rst_n;  // Pipeline reset
    logic       calibrate_pulse, kick_pulse;
    logic       strike_valid, event_valid;
    hand_t      strike_hand, event_hand;
    sample_t    strike_yaw;
    drum_code_t event_code;

    motion_if motion ();

    assign led_ready = rst_n;  // Lit once the pipeline runs

    reset_sequencer #(.SENSOR_DELAY(SENSOR_DELAY), .CONTROLLER_DELAY(CONTROLLER_DELAY))
        u_reset_sequencer (.clk(clk), .fpga_rst_n(fpga_rst_n),
                           .bno085_rst_n(bno085_rst_n), .rst_n(rst_n));

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_calibrate_debouncer (
        .clk(clk), .rst_n(rst_n), .btn_n(calibrate_btn_n), .pressed(calibrate_pulse));

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_kick_debouncer (
        .clk(clk), .rst_n(rst_n), .btn_n(kick_btn_n), .pressed(kick_pulse));

    // ======================================================================
    // Motion pipeline
    // ======================================================================

    hand_sample_merge u_hand_sample_merge (
        .clk(clk), .rst_n(rst_n),
        .right_valid(right_valid), .right_yaw(right_yaw), .right_rate(right_rate),
        .left_valid(left_valid), .left_yaw(left_yaw), .left_rate(left_rate),
        .motion(motion.src));

    strike_detector #(.STRIKE_RATE(STRIKE_RATE), .REARM_RATE(REARM_RATE)) u_strike_detector (
        .clk(clk), .rst_n(rst_n), .motion(motion.dst), .calibrate(calibrate_pulse),
        .strike_valid(strike_valid), .strike_hand(strike_hand), .strike_yaw(strike_yaw));

    drum_classifier #(.ZONE_EDGE(ZONE_EDGE)) u_drum_classifier (
        .clk(clk), .rst_n(rst_n),
        .strike_valid(strike_valid), .strike_hand(strike_hand), .strike_yaw(strike_yaw),
        .kick(kick_pulse),
        .event_valid(event_valid), .event_hand(event_hand), .event_code(event_code));

    mcu_spi_slave u_mcu_spi_slave (
        .clk(clk), .rst_n(rst_n),
        .event_valid(event_valid), .event_hand(event_hand), .event_code(event_code),
        .mcu_sck(mcu_sck), .mcu_load(mcu_load), .mcu_sdo(mcu_sdo), .mcu_done(mcu_done));

endmodule

//--- tb_drum_trigger_top.sv
`timescale 1ns/1ps

module tb_drum_trigger_top;
    import motion_pkg::*;
    import drum_pkg::*;

    localparam int MAX_CYCLES = 3000;           // About twice the summed test lengths
    localparam int HALF_SCK   = 6;              // clk cycles per sck half-period
    localparam int ZONE       = DEF_ZONE_EDGE;  // Snare half-width

    logic    clk, fpga_rst_n;
    logic    right_valid, left_valid;
    sample_t right_yaw, right_rate, left_yaw, left_rate;
    logic    calibrate_btn_n, kick_btn_n;
    logic    mcu_sck, mcu_load;
    logic    mcu_sdo, mcu_done, bno085_rst_n, led_ready;

    integer     seed;
    int         cycles, errors, test_errors, tests_passed, tests_failed;
    int         k, rel, rel2;
    string      test_name;
    hand_t      last_hand;      // Model of the merge's last grant
    hand_t      first;          // Hand served first from a same-cycle pair
    sample_t    off_r, off_l;   // Model of the calibrated centres
    logic [7:0] event_log [$];  // Classifier events seen at the SPI slave input
    logic [7:0] rx;
    logic [7:0] exp_first, exp_second;  // Expected pair events in merge order

    drum_trigger_top #(.SENSOR_DELAY(4), .CONTROLLER_DELAY(12), .DEBOUNCE_CYCLES(8))
        u_drum_trigger_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // Hard stop for a hung pipeline
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles in test %s", cycles, test_name);
            $display("TB FAILED");
            $finish;
        end
    end

    // Registered strobe, stable at the falling edge
    always @(negedge clk) begin
        if (u_drum_trigger_top.event_valid) begin
            event_log.push_back({u_drum_trigger_top.event_hand, 3'b000,
                                 u_drum_trigger_top.event_code});
        end
    end

    // Nothing may be pending while the pipeline is held in reset
    assert property (@(posedge clk) !led_ready |-> !mcu_done) else begin
        $display("%s: mcu_done went high while led_ready was low", test_name);
        errors++;
        test_errors++;
    end

    // ======================================================================
    // Checking and bookkeeping
    // ======================================================================

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (exp == act) else begin
            $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        event_log.delete();
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("[test] %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("[test] %s: fail with %0d errors", test_name, test_errors);
        end
    endtask

    // Expected MCU byte for a strike at a relative yaw
    function automatic logic [7:0] zone_byte(input hand_t hand, input int rel_yaw);
        drum_code_t code;
        code = (rel_yaw > ZONE) ? DRUM_HIHAT : (rel_yaw < -ZONE) ? DRUM_TOM : DRUM_SNARE;
        return {hand, 3'b000, code};
    endfunction

    // ======================================================================
    // Random sample values
    // ======================================================================

    function automatic sample_t rest_rate();  // At or above minus the rearm level
        int r;
        r = $unsigned($random(seed)) % 1500;
        return sample_t'(r - DEF_REARM_RATE);
    endfunction

    function automatic sample_t strike_rate();  // At or below minus the strike level
        int r;
        r = $unsigned($random(seed)) % 4000;
        return sample_t'(-DEF_STRIKE_RATE - r);
    endfunction

    function automatic int rand_rel(input int span);  // Uniform in -span..span
        int r;
        r = $unsigned($random(seed)) % (2 * span + 1);
        return r - span;
    endfunction

    // ======================================================================
    // Stimulus tasks, all driven on the falling edge
    // ======================================================================

    task automatic send_sample(input hand_t hand, input sample_t yaw, input sample_t rate);
        @(negedge clk);
        if (hand == HAND_RIGHT) begin
            right_valid = 1'b1;
            right_yaw   = yaw;
            right_rate  = rate;
        end else begin
            left_valid = 1'b1;
            left_yaw   = yaw;
            left_rate  = rate;
        end
        @(negedge clk);
        right_valid = 1'b0;  // One-cycle strobe
        left_valid  = 1'b0;
        last_hand   = hand;
    endtask

    // Both hands strobe together, last_hand ends where it started
    task automatic send_pair(input sample_t ryaw, input sample_t rrate,
                             input sample_t lyaw, input sample_t lrate);
        @(negedge clk);
        right_valid = 1'b1;
        right_yaw   = ryaw;
        right_rate  = rrate;
        left_valid  = 1'b1;
        left_yaw    = lyaw;
        left_rate   = lrate;
        @(negedge clk);
        right_valid = 1'b0;
        left_valid  = 1'b0;
    endtask

    task automatic hold_button(input bit kick, input int n);
        @(negedge clk);
        if (kick) begin
            kick_btn_n = 1'b0;
        end else begin
            calibrate_btn_n = 1'b0;
        end
        repeat (n) @(negedge clk);
        kick_btn_n      = 1'b1;  // Released
        calibrate_btn_n = 1'b1;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!mcu_done && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (mcu_done) else begin
            $display("%s: no event reached mcu_done within %0d cycles", test_name, limit);
            errors++;
            test_errors++;
        end
    endtask

    // MCU side of the link, MSB first, sampled on sck rising edges
    task automatic read_byte(output logic [7:0] data);
        int i;
        int n;
        data = '0;
        @(negedge clk);
        mcu_load = 1'b1;
        for (i = 7; i >= 0; i--) begin
            repeat (HALF_SCK) @(negedge clk);
            mcu_sck = 1'b1;
            data[i] = mcu_sdo;
            repeat (HALF_SCK) @(negedge clk);
            mcu_sck = 1'b0;  // Slave advances after this edge
        end
        repeat (HALF_SCK) @(negedge clk);
        mcu_load = 1'b0;
        n = 0;
        while (mcu_done && n < 10) begin
            @(negedge clk);
            n++;
        end
        assert (!mcu_done) else begin
            $display("%s: mcu_done still high after mcu_load fell", test_name);
            errors++;
            test_errors++;
        end
    endtask

    task automatic expect_no_event(input int n);
        repeat (n) @(negedge clk);
        compare_value("mcu_done", 0, mcu_done);
        compare_value("event count", 0, event_log.size());
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        seed            = 32'hdbb3_18b0;
        fpga_rst_n      = 1'b0;
        right_valid     = 1'b0;
        right_yaw       = '0;
        right_rate      = '0;
        left_valid      = 1'b0;
        left_yaw        = '0;
        left_rate       = '0;
        calibrate_btn_n = 1'b1;
        kick_btn_n      = 1'b1;
        mcu_sck         = 1'b0;
        mcu_load        = 1'b0;
        last_hand       = HAND_LEFT;  // Merge serves right first after reset
        test_name       = "reset";
        repeat (8) @(negedge clk);

        start_test("reset_timing");
        fpga_rst_n = 1'b1;
        for (k = 1; k <= 14; k++) begin
            @(negedge clk);  // k rising edges since release
            compare_value($sformatf("bno085_rst_n at cycle %0d", k), k >= 4, bno085_rst_n);
            compare_value($sformatf("led_ready at cycle %0d", k), k >= 12, led_ready);
            compare_value("mcu_done", 0, mcu_done);
        end
        finish_test();

        start_test("calibrate_and_zones");
        off_r = sample_t'($random(seed));
        off_l = sample_t'($random(seed));
        hold_button(1'b0, 14);
        repeat (16) @(negedge clk);  // Release settles
        // Strike-level rates, so only the calibration rule keeps them silent
        if ($random(seed) & 1) begin
            send_sample(HAND_RIGHT, off_r, strike_rate());
            send_sample(HAND_LEFT, off_l, strike_rate());
        end else begin
            send_sample(HAND_LEFT, off_l, strike_rate());
            send_sample(HAND_RIGHT, off_r, strike_rate());
        end
        expect_no_event(8);  // Calibration samples never strike
        send_sample(HAND_RIGHT, off_r, strike_rate());
        wait_done(20);
        read_byte(rx);
        compare_value("right centre byte", 8'h01, rx);
        rel = ZONE + 1 + $unsigned($random(seed)) % 1000;
        send_sample(HAND_LEFT, sample_t'(off_l + rel), strike_rate());
        wait_done(20);
        read_byte(rx);
        compare_value("left high byte", 8'h82, rx);
        finish_test();

        start_test("tom_and_both_hands");
        send_sample(HAND_LEFT, sample_t'($random(seed)), rest_rate());  // Rearm
        rel = -(ZONE + 1 + $unsigned($random(seed)) % 1000);
        send_sample(HAND_LEFT, sample_t'(off_l + rel), strike_rate());
        wait_done(20);
        read_byte(rx);
        compare_value("left tom byte", zone_byte(HAND_LEFT, rel), rx);
        event_log.delete();
        send_pair(sample_t'($random(seed)), rest_rate(), sample_t'($random(seed)), rest_rate());
        expect_no_event(6);
        rel   = rand_rel(3 * ZONE);
        rel2  = rand_rel(3 * ZONE);
        first = (last_hand == HAND_RIGHT) ? HAND_LEFT : HAND_RIGHT;
        exp_first  = (first == HAND_RIGHT) ? zone_byte(HAND_RIGHT, rel)
                     : zone_byte(HAND_LEFT, rel2);
        exp_second = (first == HAND_RIGHT) ? zone_byte(HAND_LEFT, rel2)
                     : zone_byte(HAND_RIGHT, rel);
        send_pair(sample_t'(off_r + rel), strike_rate(), sample_t'(off_l + rel2), strike_rate());
        wait_done(20);
        repeat (5) @(negedge clk);
        compare_value("event count", 2, event_log.size());
        compare_value("first event", exp_first, event_log[0]);
        compare_value("second event", exp_second, event_log[1]);
        read_byte(rx);
        compare_value("pair read byte", exp_first, rx);
        finish_test();

        start_test("one_strike_per_swing");
        send_sample(HAND_RIGHT, off_r, rest_rate());
        rel = rand_rel(3 * ZONE);
        send_sample(HAND_RIGHT, sample_t'(off_r + rel), strike_rate());
        wait_done(20);
        read_byte(rx);
        compare_value("first strike byte", zone_byte(HAND_RIGHT, rel), rx);
        event_log.delete();
        send_sample(HAND_RIGHT, sample_t'(off_r + rand_rel(3 * ZONE)), strike_rate());
        expect_no_event(10);  // Still disarmed
        send_sample(HAND_RIGHT, off_r, rest_rate());
        rel = rand_rel(3 * ZONE);
        send_sample(HAND_RIGHT, sample_t'(off_r + rel), strike_rate());
        wait_done(20);
        read_byte(rx);
        compare_value("rearmed strike byte", zone_byte(HAND_RIGHT, rel), rx);
        finish_test();

        start_test("kick_debounce");
        hold_button(1'b1, 3);  // Shorter than the debounce window
        expect_no_event(20);
        hold_button(1'b1, 14);
        wait_done(40);
        read_byte(rx);
        compare_value("kick byte", 8'h00, rx);
        finish_test();

        start_test("drop_while_pending");
        send_sample(HAND_RIGHT, off_r, rest_rate());
        rel = rand_rel(3 * ZONE);
        send_sample(HAND_RIGHT, sample_t'(off_r + rel), strike_rate());
        wait_done(20);
        send_sample(HAND_LEFT, off_l, rest_rate());
        rel2 = rand_rel(3 * ZONE);
        send_sample(HAND_LEFT, sample_t'(off_l + rel2), strike_rate());
        repeat (6) @(negedge clk);
        compare_value("event count", 2, event_log.size());  // Second reached the slave
        read_byte(rx);
        compare_value("pending byte", zone_byte(HAND_RIGHT, rel), rx);
        repeat (10) @(negedge clk);
        compare_value("mcu_done after read", 0, mcu_done);
        finish_test();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
motion_pkg.sv
drum_pkg.sv
motion_if.sv
reset_sequencer.sv
button_debouncer.sv
hand_sample_merge.sv
strike_detector.sv
drum_classifier.sv
mcu_spi_slave.sv
drum_trigger_top.sv
tb_drum_trigger_top.sv
